//--- verification/stim_program.txt
// Word 0 is the program length, then the program words in address order,
// then the expected x0 to x31 and the expected illegal_inst flag
24
FFB00093 00300113 002081B3 40110233   // addi x1 -5, addi x2 3, add, sub
0020A2B3 0020B333 FFC0A393 FFF13413   // slt, sltu, slti, sltiu
0F00C493 FF016513 07F0F593 00409613   // xori, ori, andi, slli
0040D693 4040D713 0020C7B3 0020E833   // srli, srai, xor, or
0020F8B3 00211933 002659B3 40265A33   // and, sll, srl, sra
12345AB7 00001B17 0020ABA3 06418C13   // lui, auipc, store (illegal), addi
00113CB3 00708013 00208033 01500D33   // sltu, two writes to x0, add from x0
41508DB3 408ADE13 01F11E93 41FEDF13   // sub, srai positive, slli 31, srai 31
01FEDF93 00000013 00000013 00000013   // srli 31, nop padding
// Expected x0 to x31
00000000 FFFFFFFB 00000003 FFFFFFFE
00000008 00000001 00000000 00000001
00000001 FFFFFF0B FFFFFFF3 0000007B
FFFFFFB0 0FFFFFFF FFFFFFFF FFFFFFF8
FFFFFFFB 00000003 00000018 1FFFFFF6
FFFFFFF6 12345000 00001054 00000000
00000062 00000001 12345000 EDCBAFFB
00123450 80000000 FFFFFFFF 00000001
// Expected illegal_inst
1

//--- src.f
common/core_cfg_pkg.sv
common/riscv_isa_pkg.sv
fetch/fetch_unit.sv
decode/inst_decoder.sv
execute/isa_registers.sv
execute/alu_exec.sv
hdl/rv32i_core.sv
verification/tb_rv32i_core.sv

//--- Makefile
# Verilator build, run and lint for the RV32I core

VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        := tb_rv32i_core
DUT_TOP    := rv32i_core
FILELIST   := src.f
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- verification/tb_rv32i_core.sv
/* Testbench for the RV32I core: instruction memory with random stalls,
   program and expected registers from the stim file */
module tb_rv32i_core;

    import core_cfg_pkg::*;
    import riscv_isa_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 5;
    localparam int STIM_DEPTH = 256;

    logic      aclk = 1'b0;
    logic      rst;
    logic      imem_arvalid;
    logic      imem_arready;
    word_t     imem_araddr;
    logic      imem_rvalid;
    inst_t     imem_rdata;
    logic      illegal_inst;
    reg_bank_t dbg_regs;

    // Count, program words, expected x0..x31, expected illegal flag
    word_t stim [STIM_DEPTH];
    int    prog_len;
    int    seed;
    int    cycle;
    int    req_count;
    int    resp_count;
    word_t pend_addr [$];
    int    pend_due [$];

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    rv32i_core dut (
        .aclk         (aclk),
        .rst          (rst),
        .imem_arvalid (imem_arvalid),
        .imem_arready (imem_arready),
        .imem_araddr  (imem_araddr),
        .imem_rvalid  (imem_rvalid),
        .imem_rdata   (imem_rdata),
        .illegal_inst (illegal_inst),
        .dbg_regs     (dbg_regs)
    );

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic end_with_failure();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_registers();
        int i;
        for (i = 0; i < NB_REGS; i++) begin
            check_word($sformatf("dbg_regs[x%0d]", i), dbg_regs[i*XLEN +: XLEN],
                       stim[prog_len + 1 + i]);
        end
    endtask

    //////////////////////////////////////////////////
    // Instruction memory model
    //////////////////////////////////////////////////

    function automatic inst_t inst_at(input word_t addr);
        word_t idx;
        idx = (addr - BOOT_ADDR) / word_t'(INST_BYTES);
        if (idx < word_t'(prog_len)) begin
            return stim[1 + int'(idx)];
        end
        // Fetch runs on past the program, feed it NOPs
        return {12'b0, 5'd0, F3_ADD_SUB, 5'd0, OPC_OP_IMM};
    endfunction

    initial begin : imem_model
        int    delay;
        logic  hold_arvalid;
        word_t hold_araddr;
        seed         = 32'h8eb1_b8a4;
        imem_arready = 1'b0;
        imem_rvalid  = 1'b0;
        imem_rdata   = '0;
        cycle        = 0;
        req_count    = 0;
        resp_count   = 0;
        hold_arvalid = 1'b0;
        hold_araddr  = '0;
        forever begin
            @(negedge aclk);
            // A request that was not taken must stay put
            if (hold_arvalid) begin
                check_flag("imem_arvalid", imem_arvalid, 1'b1);
                check_word("imem_araddr", imem_araddr, hold_araddr);
            end
            // Responses in request order, at most one per cycle
            imem_rvalid = 1'b0;
            imem_rdata  = '0;
            if (pend_due.size() > 0) begin
                if (pend_due[0] <= cycle) begin
                    imem_rvalid = 1'b1;
                    imem_rdata  = inst_at(pend_addr[0]);
                    void'(pend_addr.pop_front());
                    void'(pend_due.pop_front());
                    resp_count++;
                end
            end
            // Ready about three cycles in four
            imem_arready = (($random(seed) & 3) != 0);
            if (imem_arvalid && imem_arready) begin
                check_word("imem_araddr", imem_araddr,
                           BOOT_ADDR + word_t'(INST_BYTES * req_count));
                delay = $random(seed) & 3;
                pend_addr.push_back(imem_araddr);
                pend_due.push_back(cycle + 1 + delay);
                req_count++;
            end
            hold_arvalid = imem_arvalid && !imem_arready;
            hold_araddr  = imem_araddr;
            if (req_count - resp_count > FETCH_OSTD_MAX) begin
                $display("More than %0d instruction reads were open at once", FETCH_OSTD_MAX);
                end_with_failure();
            end
            cycle++;
        end
    end

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        rst      = 1'b1;
        prog_len = 0;
        $readmemh("verification/stim_program.txt", stim);
        if ((int'(stim[0]) < 1) || (int'(stim[0]) + 34 > STIM_DEPTH)) begin
            $display("The stim file holds no usable program length");
            end_with_failure();
        end
        prog_len = int'(stim[0]);
        repeat (RST_CYCLES) @(negedge aclk);
        check_flag("imem_arvalid", imem_arvalid, 1'b0);
        check_flag("illegal_inst", illegal_inst, 1'b0);
        // Every register comes out of reset cleared
        for (int r = 0; r < NB_REGS; r++) begin
            check_word($sformatf("dbg_regs[x%0d]", r), dbg_regs[r*XLEN +: XLEN], '0);
        end
        rst = 1'b0;

        wait (resp_count >= prog_len);
        // Response taken, then decode, then write-back
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        check_registers();
        check_flag("illegal_inst", illegal_inst, stim[prog_len + 33][0]);
        $display("PASS: all tests");
        $finish;
    end

    initial begin
        wait (prog_len > 0);
        repeat (40 * prog_len + 200) @(posedge aclk);
        $display("Timeout: the program did not drain within %0d cycles",
                 40 * prog_len + 200);
        end_with_failure();
    end

endmodule

//--- hdl/rv32i_core.sv
/* RV32I integer core top: fetch, decode and execute stages around the
   integer register file */
module rv32i_core (
    input  logic                    aclk,
    input  logic                    rst,
    output logic                    imem_arvalid,
    input  logic                    imem_arready,
    output core_cfg_pkg::word_t     imem_araddr,
    input  logic                    imem_rvalid,
    input  core_cfg_pkg::inst_t     imem_rdata,
    output logic                    illegal_inst,
    output core_cfg_pkg::reg_bank_t dbg_regs
);

    import core_cfg_pkg::*;
    import riscv_isa_pkg::*;

    // Fetch to decode
    logic          fetch_valid;
    inst_t         fetch_inst;
    word_t         fetch_pc;

    // Decode to execute
    decoded_inst_t dec_inst;
    word_t         dec_pc;

    // Register file ports
    reg_addr_t     rs1_addr;
    reg_addr_t     rs2_addr;
    word_t         rs1_val;
    word_t         rs2_val;
    logic          rd_wr;
    reg_addr_t     rd_addr;
    word_t         rd_val;

    //////////////////////////////////////////////////
    // Pipeline stages
    //////////////////////////////////////////////////

    fetch_unit fetch (
        .aclk         (aclk),
        .rst          (rst),
        .imem_arvalid (imem_arvalid),
        .imem_arready (imem_arready),
        .imem_araddr  (imem_araddr),
        .imem_rvalid  (imem_rvalid),
        .imem_rdata   (imem_rdata),
        .fetch_valid  (fetch_valid),
        .fetch_inst   (fetch_inst),
        .fetch_pc     (fetch_pc)
    );

    inst_decoder decoder (
        .aclk        (aclk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_inst  (fetch_inst),
        .fetch_pc    (fetch_pc),
        .dec_inst    (dec_inst),
        .dec_pc      (dec_pc)
    );

    alu_exec execute (
        .aclk         (aclk),
        .rst          (rst),
        .dec_inst     (dec_inst),
        .dec_pc       (dec_pc),
        .rs1_addr     (rs1_addr),
        .rs1_val      (rs1_val),
        .rs2_addr     (rs2_addr),
        .rs2_val      (rs2_val),
        .rd_wr        (rd_wr),
        .rd_addr      (rd_addr),
        .rd_val       (rd_val),
        .illegal_inst (illegal_inst)
    );

    //////////////////////////////////////////////////
    // Integer registers
    //////////////////////////////////////////////////

    isa_registers registers (
        .aclk     (aclk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs1_val  (rs1_val),
        .rs2_addr (rs2_addr),
        .rs2_val  (rs2_val),
        .rd_wr    (rd_wr),
        .rd_addr  (rd_addr),
        .rd_val   (rd_val),
        .dbg_regs (dbg_regs)
    );

endmodule

//--- execute/alu_exec.sv
/* Execute and write-back: selects operands, runs the integer ALU and
   writes the result, with a sticky flag for illegal instructions */
module alu_exec (
    input  logic                          aclk,
    input  logic                          rst,
    input  riscv_isa_pkg::decoded_inst_t  dec_inst,
    input  core_cfg_pkg::word_t           dec_pc,
    output core_cfg_pkg::reg_addr_t       rs1_addr,
    input  core_cfg_pkg::word_t           rs1_val,
    output core_cfg_pkg::reg_addr_t       rs2_addr,
    input  core_cfg_pkg::word_t           rs2_val,
    output logic                          rd_wr,
    output core_cfg_pkg::reg_addr_t       rd_addr,
    output core_cfg_pkg::word_t           rd_val,
    output logic                          illegal_inst
);

    import core_cfg_pkg::*;
    import riscv_isa_pkg::*;

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;

    assign rs1_addr = dec_inst.rs1;
    assign rs2_addr = dec_inst.rs2;

    // PC for AUIPC, zero for LUI, else the rs1 register
    assign op_a  = dec_inst.use_pc   ? dec_pc :
                   dec_inst.rs1_zero ? '0     : rs1_val;
    assign op_b  = dec_inst.use_imm  ? dec_inst.imm : rs2_val;
    assign shamt = op_b[4:0];

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////

    always_comb begin
        case (dec_inst.alu_op)
            ALU_ADD:  rd_val = op_a + op_b;
            ALU_SUB:  rd_val = op_a - op_b;
            ALU_SLL:  rd_val = op_a << shamt;
            ALU_SLT:  rd_val = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: rd_val = word_t'(op_a < op_b);
            ALU_XOR:  rd_val = op_a ^ op_b;
            ALU_SRL:  rd_val = op_a >> shamt;
            ALU_SRA:  rd_val = word_t'($signed(op_a) >>> shamt);
            ALU_OR:   rd_val = op_a | op_b;
            ALU_AND:  rd_val = op_a & op_b;
            default:  rd_val = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Write-back and status
    //////////////////////////////////////////////////

    // The register file samples the strobe on the same edge
    assign rd_wr   = dec_inst.valid & ~dec_inst.illegal;
    assign rd_addr = dec_inst.rd;

    always_ff @(posedge aclk) begin
        if (rst) begin
            illegal_inst <= 1'b0;
        end else if (dec_inst.valid && dec_inst.illegal) begin
            illegal_inst <= 1'b1;
        end
    end

endmodule

//--- execute/isa_registers.sv
/* Integer register file: two combinational read ports, one write port,
   x0 hardwired to zero, every register visible on the debug bus */
module isa_registers (
    input  logic                    aclk,
    input  logic                    rst,
    input  core_cfg_pkg::reg_addr_t rs1_addr,
    output core_cfg_pkg::word_t     rs1_val,
    input  core_cfg_pkg::reg_addr_t rs2_addr,
    output core_cfg_pkg::word_t     rs2_val,
    input  logic                    rd_wr,
    input  core_cfg_pkg::reg_addr_t rd_addr,
    input  core_cfg_pkg::word_t     rd_val,
    output core_cfg_pkg::reg_bank_t dbg_regs
);

    import core_cfg_pkg::*;

    word_t regs [NB_REGS];

    // Writes to x0 are dropped, so it keeps its reset value
    always_ff @(posedge aclk) begin
        if (rst) begin
            for (int i = 0; i < NB_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wr && (rd_addr != '0)) begin
            regs[rd_addr] <= rd_val;
        end
    end

    assign rs1_val = regs[rs1_addr];
    assign rs2_val = regs[rs2_addr];

    always_comb begin
        for (int i = 0; i < NB_REGS; i++) begin
            dbg_regs[i*XLEN +: XLEN] = regs[i];
        end
    end

endmodule

//--- decode/inst_decoder.sv
/* Instruction decode: splits the fetched word into operand selects, ALU
   operation and immediate, then registers the result for execute */
module inst_decoder (
    input  logic                          aclk,
    input  logic                          rst,
    input  logic                          fetch_valid,
    input  core_cfg_pkg::inst_t           fetch_inst,
    input  core_cfg_pkg::word_t           fetch_pc,
    output riscv_isa_pkg::decoded_inst_t  dec_inst,
    output core_cfg_pkg::word_t           dec_pc
);

    import core_cfg_pkg::*;
    import riscv_isa_pkg::*;

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    word_t         imm_i;
    word_t         imm_u;
    decoded_inst_t dec_next;

    //////////////////////////////////////////////////
    // Field extraction
    //////////////////////////////////////////////////

    assign opcode = fetch_inst[6:0];
    assign funct3 = fetch_inst[14:12];
    assign funct7 = fetch_inst[31:25];

    assign imm_i = {{20{fetch_inst[31]}}, fetch_inst[31:20]};
    assign imm_u = {fetch_inst[31:12], 12'b0};

    //////////////////////////////////////////////////
    // Operation mapping
    //////////////////////////////////////////////////

    always_comb begin
        dec_next          = '0;
        dec_next.valid    = fetch_valid;
        dec_next.alu_op   = ALU_ADD;
        dec_next.rs1      = fetch_inst[19:15];
        dec_next.rs2      = fetch_inst[24:20];
        dec_next.rd       = fetch_inst[11:7];
        dec_next.imm      = imm_i;

        case (opcode)
            OPC_OP_IMM: begin
                dec_next.use_imm = 1'b1;
                case (funct3)
                    F3_ADD_SUB: dec_next.alu_op = ALU_ADD;
                    F3_SLT:     dec_next.alu_op = ALU_SLT;
                    F3_SLTU:    dec_next.alu_op = ALU_SLTU;
                    F3_XOR:     dec_next.alu_op = ALU_XOR;
                    F3_OR:      dec_next.alu_op = ALU_OR;
                    F3_AND:     dec_next.alu_op = ALU_AND;
                    F3_SLL: begin
                        dec_next.alu_op  = ALU_SLL;
                        dec_next.illegal = (funct7 != F7_BASE);
                    end
                    default: begin
                        // Shift right, funct7 sits in the upper immediate bits
                        dec_next.alu_op  = funct7[5] ? ALU_SRA : ALU_SRL;
                        dec_next.illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
                    end
                endcase
            end
            OPC_OP: begin
                // Only bit 5 of funct7 may be set, and only for SUB and SRA
                dec_next.illegal = ((funct7 & ~F7_ALT) != F7_BASE);
                case (funct3)
                    F3_ADD_SUB: dec_next.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    F3_SRL_SRA: dec_next.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                    F3_SLL:     dec_next.alu_op = ALU_SLL;
                    F3_SLT:     dec_next.alu_op = ALU_SLT;
                    F3_SLTU:    dec_next.alu_op = ALU_SLTU;
                    F3_XOR:     dec_next.alu_op = ALU_XOR;
                    F3_OR:      dec_next.alu_op = ALU_OR;
                    default:    dec_next.alu_op = ALU_AND;
                endcase
                if ((funct3 != F3_ADD_SUB) && (funct3 != F3_SRL_SRA) && funct7[5]) begin
                    dec_next.illegal = 1'b1;
                end
            end
            OPC_LUI: begin
                dec_next.use_imm  = 1'b1;
                dec_next.rs1_zero = 1'b1;
                dec_next.imm      = imm_u;
            end
            OPC_AUIPC: begin
                dec_next.use_imm = 1'b1;
                dec_next.use_pc  = 1'b1;
                dec_next.imm     = imm_u;
            end
            default: dec_next.illegal = 1'b1;
        endcase
    end

    //////////////////////////////////////////////////
    // Decode stage register
    //////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (rst) begin
            dec_inst.valid <= 1'b0;
        end else begin
            dec_inst <= dec_next;
        end
    end

    always_ff @(posedge aclk) begin
        dec_pc <= fetch_pc;
    end

endmodule

//--- fetch/fetch_unit.sv
/* Instruction fetch: streams read requests from the boot address, bounds
   the reads in flight and tags each returned word with its PC */
module fetch_unit (
    input  logic                aclk,
    input  logic                rst,
    output logic                imem_arvalid,
    input  logic                imem_arready,
    output core_cfg_pkg::word_t imem_araddr,
    input  logic                imem_rvalid,
    input  core_cfg_pkg::inst_t imem_rdata,
    output logic                fetch_valid,
    output core_cfg_pkg::inst_t fetch_inst,
    output core_cfg_pkg::word_t fetch_pc
);

    import core_cfg_pkg::*;

    logic                  req_acc;
    logic [OSTD_CNT_W-1:0] ostd_cnt;
    logic [OSTD_CNT_W-1:0] ostd_next;
    word_t                 resp_pc;

    //////////////////////////////////////////////////
    // Request side
    //////////////////////////////////////////////////

    assign req_acc = imem_arvalid & imem_arready;

    // Responses are never refused, so every rvalid retires one read
    assign ostd_next = ostd_cnt + OSTD_CNT_W'(req_acc) - OSTD_CNT_W'(imem_rvalid);

    always_ff @(posedge aclk) begin
        if (rst) begin
            ostd_cnt     <= '0;
            imem_arvalid <= 1'b0;
        end else begin
            ostd_cnt     <= ostd_next;
            // Only rises while below the limit and the count can only fall
            // before acceptance, so a pending request is never withdrawn
            imem_arvalid <= (ostd_next < FETCH_OSTD_MAX);
        end
    end

    // Sequential addresses only, no branches to redirect fetch
    always_ff @(posedge aclk) begin
        if (rst) begin
            imem_araddr <= BOOT_ADDR;
        end else if (req_acc) begin
            imem_araddr <= imem_araddr + word_t'(INST_BYTES);
        end
    end

    //////////////////////////////////////////////////
    // Response side
    //////////////////////////////////////////////////

    // Responses return in request order, so a second counter tracks the PC
    always_ff @(posedge aclk) begin
        if (rst) begin
            resp_pc     <= BOOT_ADDR;
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= imem_rvalid;
            if (imem_rvalid) begin
                resp_pc <= resp_pc + word_t'(INST_BYTES);
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (imem_rvalid) begin
            fetch_inst <= imem_rdata;
            fetch_pc   <= resp_pc;
        end
    end

endmodule

//--- common/riscv_isa_pkg.sv
/* RV32I encodings for the integer subset, the ALU operation codes and
   the decoded instruction passed from decode to execute */
package riscv_isa_pkg;

    //////////////////////////////////////////////////
    // Major opcodes
    //////////////////////////////////////////////////

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    //////////////////////////////////////////////////
    // funct3 and funct7 codes
    //////////////////////////////////////////////////

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Base form and the alternate form for SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    //////////////////////////////////////////////////
    // Decoded instruction
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef struct packed {
        logic                  valid;
        alu_op_t               alu_op;
        core_cfg_pkg::reg_addr_t rs1;
        core_cfg_pkg::reg_addr_t rs2;
        core_cfg_pkg::reg_addr_t rd;
        logic                  use_imm;
        logic                  use_pc;
        logic                  rs1_zero;
        core_cfg_pkg::word_t   imm;
        logic                  illegal;
    } decoded_inst_t;

endpackage

//--- common/core_cfg_pkg.sv
/* Core configuration: widths, boot address, fetch depth and the basic
   word, address and register bank types shared by every stage */
package core_cfg_pkg;

    //////////////////////////////////////////////////
    // Architecture widths
    //////////////////////////////////////////////////

    localparam int XLEN    = 32;
    localparam int ILEN    = 32;
    localparam int NB_REGS = 32;

    // Register index width follows the register count
    localparam int REG_ADDR_W = $clog2(NB_REGS);

    //////////////////////////////////////////////////
    // Fetch setup
    //////////////////////////////////////////////////

    localparam logic [XLEN-1:0] BOOT_ADDR = '0;

    // Most instruction reads open on the bus at once
    localparam int FETCH_OSTD_MAX = 2;
    localparam int OSTD_CNT_W     = $clog2(FETCH_OSTD_MAX + 1);

    // Address step between two instructions
    localparam int INST_BYTES = 4;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    typedef logic [XLEN-1:0]         word_t;
    typedef logic [ILEN-1:0]         inst_t;
    typedef logic [REG_ADDR_W-1:0]   reg_addr_t;
    // All registers side by side, x0 in the low word
    typedef logic [NB_REGS*XLEN-1:0] reg_bank_t;

endpackage
